/* build.f */
common/alloc_pkg.sv
alloc_bv/alloc_bitmap.sv
alloc_bv/alloc_scan.sv
alloc_bv/dealloc_check.sv
alloc_bv/alloc_bv.sv
tests/alloc_bv_chk.sv
tests/alloc_bv_tb.sv

/* Makefile */
# Verilator simulation of the bit-vector pointer allocator

VERILATOR ?= verilator
TOP       ?= alloc_bv_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

# Build, run, and fail unless the pass message shows up
sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/alloc_bv_tb.sv */
module alloc_bv_tb;

    // ==============================
    // Run limits
    // ==============================
    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS = 5;
    // Gap, grant, release and slack for one handshake
    localparam int WORST_HS = 40;
    localparam int ACK_LIMIT = 50;
    localparam int WATCHDOG = alloc_pkg::NUM_PTRS * NUM_TESTS * WORST_HS * CLK_PERIOD;
    localparam int QUARTER = alloc_pkg::NUM_PTRS / 4;

    logic                          clk;
    logic                          rst_n;
    logic                          alloc_req;
    logic                          alloc_ack;
    logic [alloc_pkg::PTR_WID-1:0] alloc_ptr;
    logic                          alloc_full;
    logic                          dealloc_req;
    logic                          dealloc_ack;
    logic [alloc_pkg::PTR_WID-1:0] dealloc_ptr;
    logic                          dealloc_err;
    logic [alloc_pkg::PTR_WID-1:0] err_ptr;
    logic                          init_done;
    logic [alloc_pkg::CNT_WID-1:0] free_count;

    int          err_cnt;
    int          chk_cnt;
    int          exp_free;
    logic [31:0] lfsr_state;

    alloc_bv alloc_bv_i (
        .clk(clk), .rst_n(rst_n),
        .alloc_req(alloc_req), .alloc_ack(alloc_ack),
        .alloc_ptr(alloc_ptr), .alloc_full(alloc_full),
        .dealloc_req(dealloc_req), .dealloc_ack(dealloc_ack), .dealloc_ptr(dealloc_ptr),
        .dealloc_err(dealloc_err), .err_ptr(err_ptr),
        .init_done(init_done), .free_count(free_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    // Hard stop if a handshake hangs
    initial begin
        #(WATCHDOG);
        $display("Watchdog expired after %0d time units, tests did not complete", WATCHDOG);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ==============================
    // Helpers
    // ==============================
    task automatic check_val(input string name, input int exp_val, input int act_val);
        chk_cnt++;
        assert (act_val == exp_val) else begin
            err_cnt++;
            $display("Mismatch in %s: expected %0d, actual %0d", name, exp_val, act_val);
        end
    endtask

    // Taps 32 22 2 1
    // One step per bit taken
    function automatic int rand_bits(input int n);
        int   val;
        logic fb;
        val = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = (val << 1) | int'(fb);
        end
        return val;
    endfunction

    // Four-phase allocate that ends on a falling edge
    task automatic do_alloc(input string name, input int exp_ptr);
        int waited;
        waited = 0;
        @(posedge clk);
        alloc_req <= 1'b1;
        do begin
            @(posedge clk);
            waited++;
            @(negedge clk);
        end while (!alloc_ack && waited < ACK_LIMIT);
        assert (alloc_ack) else begin
            err_cnt++;
            $display("%s: alloc_ack did not rise within %0d cycles", name, ACK_LIMIT);
        end
        if (alloc_ack) begin
            exp_free--;
            check_val(name, exp_ptr, int'(alloc_ptr));
            check_val({name, " free_count"}, exp_free, int'(free_count));
        end
        @(posedge clk);
        alloc_req <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            @(negedge clk);
        end while (alloc_ack && waited < ACK_LIMIT);
        assert (!alloc_ack) else begin
            err_cnt++;
            $display("%s: alloc_ack stayed high after alloc_req dropped", name);
        end
    endtask

    // Four-phase deallocate with one cycle fixed latency
    task automatic do_dealloc(input string name, input int ptr, input int exp_err);
        int waited;
        waited = 0;
        @(posedge clk);
        dealloc_req <= 1'b1;
        dealloc_ptr <= ptr[alloc_pkg::PTR_WID-1:0];
        do begin
            @(posedge clk);
            waited++;
            @(negedge clk);
        end while (!dealloc_ack && waited < ACK_LIMIT);
        assert (dealloc_ack) else begin
            err_cnt++;
            $display("%s: dealloc_ack did not rise within %0d cycles", name, ACK_LIMIT);
        end
        if (dealloc_ack) begin
            // Valid return frees one pointer and a double free changes nothing
            if (exp_err == 0) begin
                exp_free++;
            end
            check_val({name, " latency"}, 1, waited);
            check_val({name, " dealloc_err"}, exp_err, int'(dealloc_err));
            if (exp_err != 0) begin
                check_val({name, " err_ptr"}, ptr, int'(err_ptr));
            end
            check_val({name, " free_count"}, exp_free, int'(free_count));
        end
        @(posedge clk);
        dealloc_req <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            @(negedge clk);
        end while (dealloc_ack && waited < ACK_LIMIT);
        assert (!dealloc_ack) else begin
            err_cnt++;
            $display("%s: dealloc_ack stayed high after dealloc_req dropped", name);
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic run_reset();
        int edges;
        edges = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        // Count rising edges with rst_n high until the sweep ends
        while (!init_done && edges < 4 * alloc_pkg::NUM_WORDS) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        check_val("reset init edges", alloc_pkg::NUM_WORDS, edges);
        exp_free = alloc_pkg::NUM_PTRS;
        check_val("reset free_count", exp_free, int'(free_count));
        check_val("reset alloc_full", 0, int'(alloc_full));
    endtask

    task automatic run_single();
        do_alloc("single alloc", 0);
        do_dealloc("single dealloc", 0, 0);
    endtask

    task automatic run_exhaust();
        for (int i = 0; i < alloc_pkg::NUM_PTRS; i++) begin
            repeat (rand_bits(2)) @(posedge clk);
            do_alloc("exhaust alloc", i);
        end
        check_val("exhaust alloc_full", 1, int'(alloc_full));
        // Request parked against a full pool, then withdrawn
        @(posedge clk);
        alloc_req <= 1'b1;
        repeat (20) begin
            @(posedge clk);
            @(negedge clk);
            assert (!alloc_ack) else begin
                err_cnt++;
                $display("exhaust: alloc_ack rose while the pool was full");
            end
        end
        @(posedge clk);
        alloc_req <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_val("exhaust withdrawn ack", 0, int'(alloc_ack));
        for (int i = 0; i < alloc_pkg::NUM_PTRS; i++) begin
            do_dealloc("exhaust dealloc", i, 0);
        end
    endtask

    task automatic run_lowest();
        int first_ptr;
        for (int i = 0; i < 8; i++) begin
            do_alloc("lowest fill", i);
        end
        first_ptr = (rand_bits(1) != 0) ? 5 : 2;
        do_dealloc("lowest dealloc", first_ptr, 0);
        do_dealloc("lowest dealloc", 7 - first_ptr, 0);
        // Order of return must not matter
        do_alloc("lowest realloc", 2);
        do_alloc("lowest realloc", 5);
        for (int i = 0; i < 8; i++) begin
            do_dealloc("lowest cleanup", i, 0);
        end
    endtask

    task automatic run_double();
        int order [QUARTER];
        int j;
        int tmp;
        int picked;
        picked = 0;
        for (int i = 0; i < QUARTER; i++) begin
            do_alloc("double fill", i);
            order[i] = i;
        end
        // Fisher-Yates shuffle
        for (int i = QUARTER - 1; i > 0; i--) begin
            j = rand_bits(8) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < QUARTER; i++) begin
            do_dealloc("double first free", order[i], 0);
        end
        // Last pointer forced in if nothing was picked
        for (int i = 0; i < QUARTER; i++) begin
            if (rand_bits(1) != 0 || (i == QUARTER - 1 && picked == 0)) begin
                do_dealloc("double second free", i, 1);
                picked++;
            end
        end
        check_val("double free_count", alloc_pkg::NUM_PTRS, int'(free_count));
    endtask

    initial begin
        rst_n = 1'b0;
        alloc_req = 1'b0;
        dealloc_req = 1'b0;
        dealloc_ptr = '0;
        err_cnt = 0;
        chk_cnt = 0;
        exp_free = 0;
        lfsr_state = 32'h9dfb;
        run_reset();
        run_single();
        run_exhaust();
        run_lowest();
        run_double();
        repeat (4) @(posedge clk);
        // Protocol assertion failures from the bound checker
        err_cnt += alloc_bv_i.alloc_bv_chk_i.fail_cnt;
        $display("Checks: %0d, assertion failures: %0d, errors: %0d",
                 chk_cnt, alloc_bv_i.alloc_bv_chk_i.fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* tests/alloc_bv_chk.sv */
module alloc_bv_chk (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          alloc_req,
    input logic                          alloc_ack,
    input logic [alloc_pkg::PTR_WID-1:0] alloc_ptr,
    input logic                          dealloc_req,
    input logic                          dealloc_ack,
    input logic                          dealloc_err,
    input logic                          init_done
);

    // Running total of failed assertions
    int fail_cnt = 0;

    // ==============================
    // Handshake protocol
    // ==============================

    // Quiet during the init sweep
    no_ack_before_init: assert property (@(posedge clk) disable iff (!rst_n)
        !init_done |-> !alloc_ack && !dealloc_ack && !dealloc_err)
        else begin
            fail_cnt++;
            $error("ack or dealloc_err high before init_done");
        end

    // Granted pointer frozen for the whole ack phase
    alloc_ptr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_ack && $past(alloc_ack) |-> alloc_ptr == $past(alloc_ptr))
        else begin
            fail_cnt++;
            $error("alloc_ptr changed while alloc_ack was high");
        end

    // Ack drops only once req was seen low
    alloc_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(alloc_ack) |-> !$past(alloc_req))
        else begin
            fail_cnt++;
            $error("alloc_ack fell while alloc_req was still high");
        end

    dealloc_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(dealloc_ack) |-> !$past(dealloc_req))
        else begin
            fail_cnt++;
            $error("dealloc_ack fell while dealloc_req was still high");
        end

    // Error is a single-cycle pulse
    err_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dealloc_err) |=> !dealloc_err)
        else begin
            fail_cnt++;
            $error("dealloc_err stayed high for more than one cycle");
        end

endmodule

bind alloc_bv alloc_bv_chk alloc_bv_chk_i (
    .clk(clk), .rst_n(rst_n),
    .alloc_req(alloc_req), .alloc_ack(alloc_ack), .alloc_ptr(alloc_ptr),
    .dealloc_req(dealloc_req), .dealloc_ack(dealloc_ack), .dealloc_err(dealloc_err),
    .init_done(init_done)
);

/* alloc_bv/alloc_bv.sv */
module alloc_bv (
    input  logic                             clk,
    input  logic                             rst_n,
    // Allocate channel
    input  logic                             alloc_req,
    output logic                             alloc_ack,
    output logic [alloc_pkg::PTR_WID-1:0]    alloc_ptr,
    output logic                             alloc_full,
    // Deallocate channel
    input  logic                             dealloc_req,
    output logic                             dealloc_ack,
    input  logic [alloc_pkg::PTR_WID-1:0]    dealloc_ptr,
    output logic                             dealloc_err,
    output logic [alloc_pkg::PTR_WID-1:0]    err_ptr,
    // Status
    output logic                             init_done,
    output logic [alloc_pkg::CNT_WID-1:0]    free_count
);

    // Stage to bitmap
    logic                          set_en;
    logic [alloc_pkg::PTR_WID-1:0] set_ptr;
    logic                          clr_en;
    logic [alloc_pkg::PTR_WID-1:0] clr_ptr;

    // Bitmap to both stages
    logic [alloc_pkg::NUM_PTRS-1:0] bitmap;

    // ==============================
    // Shared bitmap stage
    // ==============================
    alloc_bitmap alloc_bitmap_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .set_en     (set_en),
        .set_ptr    (set_ptr),
        .clr_en     (clr_en),
        .clr_ptr    (clr_ptr),
        .bitmap     (bitmap),
        .free_count (free_count),
        .init_done  (init_done)
    );

    // Allocate side
    alloc_scan alloc_scan_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_req  (alloc_req),
        .alloc_ack  (alloc_ack),
        .alloc_ptr  (alloc_ptr),
        .alloc_full (alloc_full),
        .bitmap     (bitmap),
        .free_count (free_count),
        .init_done  (init_done),
        .set_en     (set_en),
        .set_ptr    (set_ptr)
    );

    // Deallocate side
    dealloc_check dealloc_check_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .dealloc_req (dealloc_req),
        .dealloc_ptr (dealloc_ptr),
        .dealloc_ack (dealloc_ack),
        .dealloc_err (dealloc_err),
        .err_ptr     (err_ptr),
        .bitmap      (bitmap),
        .init_done   (init_done),
        .clr_en      (clr_en),
        .clr_ptr     (clr_ptr)
    );

endmodule

/* alloc_bv/dealloc_check.sv */
module dealloc_check (
    input  logic                             clk,
    input  logic                             rst_n,
    // Deallocate channel
    input  logic                             dealloc_req,
    input  logic [alloc_pkg::PTR_WID-1:0]    dealloc_ptr,
    output logic                             dealloc_ack,
    output logic                             dealloc_err,
    output logic [alloc_pkg::PTR_WID-1:0]    err_ptr,
    // From the bitmap stage
    input  logic [alloc_pkg::NUM_PTRS-1:0]   bitmap,
    input  logic                             init_done,
    // Clear port to the bitmap stage
    output logic                             clr_en,
    output logic [alloc_pkg::PTR_WID-1:0]    clr_ptr
);

    // ==============================
    // Validation
    // ==============================

    alloc_pkg::hs_state_e hs_state;

    // Request accepted this cycle
    logic take;

    // Pointer currently marked allocated
    logic ptr_taken;

    // Double free
    logic bad_free;

    assign ptr_taken = bitmap[dealloc_ptr];

    // Only idle and after the sweep
    assign take = (hs_state == alloc_pkg::HS_IDLE) && dealloc_req && init_done;

    assign bad_free = take && !ptr_taken;

    // Valid return clears on the edge ack rises
    assign clr_en  = take && ptr_taken;
    assign clr_ptr = dealloc_ptr;

    // ==============================
    // Deallocate handshake
    // ==============================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_state    <= alloc_pkg::HS_IDLE;
            dealloc_err <= 1'b0;
        end else begin
            // Single-cycle pulse, take is low once in HS_ACK
            dealloc_err <= bad_free;
            case (hs_state)
                alloc_pkg::HS_IDLE: begin
                    // Good or bad, the handshake completes
                    if (take) begin
                        hs_state <= alloc_pkg::HS_ACK;
                    end
                end
                alloc_pkg::HS_ACK: begin
                    if (!dealloc_req) begin
                        hs_state <= alloc_pkg::HS_RELEASE;
                    end
                end
                // Ack low for one cycle before accepting again
                alloc_pkg::HS_RELEASE: hs_state <= alloc_pkg::HS_IDLE;
                default:               hs_state <= alloc_pkg::HS_IDLE;
            endcase
        end
    end

    // Offending pointer, held until the next error
    always_ff @(posedge clk) begin
        if (bad_free) begin
            err_ptr <= dealloc_ptr;
        end
    end

    assign dealloc_ack = (hs_state == alloc_pkg::HS_ACK);

endmodule

/* alloc_bv/alloc_scan.sv */
module alloc_scan (
    input  logic                             clk,
    input  logic                             rst_n,
    // Allocate channel
    input  logic                             alloc_req,
    output logic                             alloc_ack,
    output logic [alloc_pkg::PTR_WID-1:0]    alloc_ptr,
    output logic                             alloc_full,
    // From the bitmap stage
    input  logic [alloc_pkg::NUM_PTRS-1:0]   bitmap,
    input  logic [alloc_pkg::CNT_WID-1:0]    free_count,
    input  logic                             init_done,
    // Set port to the bitmap stage
    output logic                             set_en,
    output logic [alloc_pkg::PTR_WID-1:0]    set_ptr
);

    // ==============================
    // Lowest-free search
    // ==============================

    logic [alloc_pkg::PTR_WID-1:0] lowest_ptr;
    logic                          lowest_found;

    // Candidate held for the next grant
    logic [alloc_pkg::PTR_WID-1:0] cand_ptr;
    logic                          cand_valid;

    alloc_pkg::hs_state_e          hs_state;
    logic                          grant;

    // Priority encoder, first clear bit from index 0 wins
    always_comb begin
        lowest_ptr   = '0;
        lowest_found = 1'b0;
        for (int i = 0; i < alloc_pkg::NUM_PTRS; i++) begin
            if (!lowest_found && !bitmap[i]) begin
                lowest_ptr   = i[alloc_pkg::PTR_WID-1:0];
                lowest_found = 1'b1;
            end
        end
    end

    // ==============================
    // Candidate register
    // ==============================

    // Frozen while ack is high
    // The release cycle reloads it from the bitmap with the last set applied
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cand_valid <= 1'b0;
        end else if (hs_state != alloc_pkg::HS_ACK) begin
            // Nothing valid before the sweep ends
            cand_valid <= init_done && lowest_found;
        end
    end

    always_ff @(posedge clk) begin
        if (hs_state != alloc_pkg::HS_ACK) begin
            cand_ptr <= lowest_ptr;
        end
    end

    // ==============================
    // Allocate handshake
    // ==============================

    // Grant when idle, requested and a candidate is ready
    assign grant = (hs_state == alloc_pkg::HS_IDLE) && alloc_req
                   && init_done && cand_valid;

    // Bitmap bit sets on the same edge ack rises
    assign set_en  = grant;
    assign set_ptr = cand_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_state <= alloc_pkg::HS_IDLE;
        end else begin
            case (hs_state)
                alloc_pkg::HS_IDLE: begin
                    if (grant) begin
                        hs_state <= alloc_pkg::HS_ACK;
                    end
                end
                // Hold ack until the client drops req
                alloc_pkg::HS_ACK: begin
                    if (!alloc_req) begin
                        hs_state <= alloc_pkg::HS_RELEASE;
                    end
                end
                // Ack low, candidate refresh
                alloc_pkg::HS_RELEASE: hs_state <= alloc_pkg::HS_IDLE;
                default:               hs_state <= alloc_pkg::HS_IDLE;
            endcase
        end
    end

    // Pointer stays put for the whole ack phase
    always_ff @(posedge clk) begin
        if (grant) begin
            alloc_ptr <= cand_ptr;
        end
    end

    assign alloc_ack = (hs_state == alloc_pkg::HS_ACK);

    // Back-pressure flag
    assign alloc_full = (free_count == '0);

endmodule

/* alloc_bv/alloc_bitmap.sv */
module alloc_bitmap (
    input  logic                             clk,
    input  logic                             rst_n,
    // Set port from the scan stage
    input  logic                             set_en,
    input  logic [alloc_pkg::PTR_WID-1:0]    set_ptr,
    // Clear port from the check stage
    input  logic                             clr_en,
    input  logic [alloc_pkg::PTR_WID-1:0]    clr_ptr,
    // Flat view of every allocated bit
    output logic [alloc_pkg::NUM_PTRS-1:0]   bitmap,
    output logic [alloc_pkg::CNT_WID-1:0]    free_count,
    output logic                             init_done
);

    // ==============================
    // Storage and state
    // ==============================

    // Word array, bit set means pointer taken
    logic [alloc_pkg::WORD_W-1:0] words [alloc_pkg::NUM_WORDS];
    logic [alloc_pkg::WORD_W-1:0] words_next [alloc_pkg::NUM_WORDS];

    // One-hot request vectors across the whole pointer space
    logic [alloc_pkg::NUM_PTRS-1:0] set_vec;
    logic [alloc_pkg::NUM_PTRS-1:0] clr_vec;

    alloc_pkg::init_state_e         init_state;
    logic [alloc_pkg::WORD_IDX_W-1:0] sweep_idx;

    // ==============================
    // Init sweep FSM
    // ==============================

    // Walks every word once after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_state <= alloc_pkg::INIT_SWEEP;
            sweep_idx  <= '0;
        end else if (init_state == alloc_pkg::INIT_SWEEP) begin
            sweep_idx <= sweep_idx + 1'b1;
            // Last word cleared on this edge
            if (sweep_idx == alloc_pkg::LAST_WORD) begin
                init_state <= alloc_pkg::INIT_DONE;
            end
        end
    end

    assign init_done = (init_state == alloc_pkg::INIT_DONE);

    // ==============================
    // Set and clear
    // ==============================

    // Decode both ports to one-hot
    always_comb begin
        set_vec = '0;
        clr_vec = '0;
        if (set_en) begin
            set_vec[set_ptr] = 1'b1;
        end
        if (clr_en) begin
            clr_vec[clr_ptr] = 1'b1;
        end
    end

    // Per-word next value
    // Set and clear never hit the same bit, so order does not matter
    always_comb begin
        for (int w = 0; w < alloc_pkg::NUM_WORDS; w++) begin
            words_next[w] = (words[w] | set_vec[w*alloc_pkg::WORD_W +: alloc_pkg::WORD_W])
                            & ~clr_vec[w*alloc_pkg::WORD_W +: alloc_pkg::WORD_W];
        end
    end

    // Sweep owns the array until done
    always_ff @(posedge clk) begin
        for (int w = 0; w < alloc_pkg::NUM_WORDS; w++) begin
            if (init_state == alloc_pkg::INIT_SWEEP) begin
                if (int'(sweep_idx) == w) begin
                    words[w] <= '0;
                end
            end else begin
                words[w] <= words_next[w];
            end
        end
    end

    // Flatten for the search and the check
    always_comb begin
        for (int w = 0; w < alloc_pkg::NUM_WORDS; w++) begin
            bitmap[w*alloc_pkg::WORD_W +: alloc_pkg::WORD_W] = words[w];
        end
    end

    // ==============================
    // Free count
    // ==============================

    // Down on set, up on clear, hold when both or neither
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_count <= alloc_pkg::ALL_FREE;
        end else if (init_state == alloc_pkg::INIT_DONE) begin
            case ({set_en, clr_en})
                2'b10:   free_count <= free_count - 1'b1;
                2'b01:   free_count <= free_count + 1'b1;
                default: free_count <= free_count;
            endcase
        end
    end

endmodule

/* common/alloc_pkg.sv */
package alloc_pkg;

    // ==============================
    // Pointer space
    // ==============================

    // Pointer width sets everything else
    localparam int PTR_WID = 6;
    localparam int NUM_PTRS = 2 ** PTR_WID;

    // Free count must reach NUM_PTRS, hence one extra bit
    localparam int CNT_WID = PTR_WID + 1;

    // ==============================
    // Bitmap organisation
    // ==============================

    // One word cleared per cycle during the sweep
    localparam int WORD_W = 8;
    localparam int NUM_WORDS = NUM_PTRS / WORD_W;

    // Sweep counter width
    localparam int WORD_IDX_W = $clog2(NUM_WORDS);

    // Sweep stops on this word
    localparam logic [WORD_IDX_W-1:0] LAST_WORD = WORD_IDX_W'(NUM_WORDS - 1);

    // Free count right after init
    localparam logic [CNT_WID-1:0] ALL_FREE = CNT_WID'(NUM_PTRS);

    // ==============================
    // State encodings
    // ==============================

    // Init sweep, then normal operation
    typedef enum logic {
        INIT_SWEEP,
        INIT_DONE
    } init_state_e;

    // Four-phase handshake
    // HS_RELEASE is one spare cycle with ack low before the next req
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_ACK,
        HS_RELEASE
    } hs_state_e;

endpackage
